// File: bench/bicubic_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bicubic reference model, LFSR and window table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BICUBIC_MODEL_SVH
`define BICUBIC_MODEL_SVH

localparam int NUM_DIRECTED = 4;
localparam int NUM_RANDOM   = 60;
localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;

// 16 raster pixels per window, RGB with R in the top byte
logic [23:0] win_tab [NUM_ROWS][16];
logic [23:0] exp_tab [NUM_ROWS];

// 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

// Catmull-Rom at the half point
function automatic int tap_weight(input int idx);
    return (idx == 1 || idx == 2) ? 9 : -1;
endfunction

// full 2-D weighted sum, then round, scale by 1/256 and clamp
function automatic logic [23:0] model_pixel(input int row);
    int          acc;
    int          val;
    logic [23:0] pix;
    pix = '0;
    for (int ch = 0; ch < 3; ch++) begin
        acc = 0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                acc = acc + tap_weight(y) * tap_weight(x)
                          * int'(win_tab[row][y*4 + x][8*ch +: 8]);
            end
        end
        val = (acc + 128) >>> 8;
        if (val < 0) begin
            val = 0;
        end else if (val > 255) begin
            val = 255;
        end
        pix[8*ch +: 8] = val[7:0];
    end
    return pix;
endfunction

`endif

// File: bench/bicubic_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the bicubic upsampler
// windows from a table, scoreboard on the write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bicubic_tb;

    `include "bicubic_model.svh"

    localparam int CLK_PERIOD_NS     = 4;
    localparam int RANDOM_STALL_FROM = 20;
    localparam int LONG_STALL_AT     = 40;
    localparam int LONG_STALL_CYCLES = 200;
    localparam int WATCHDOG_NS       = 40 * NUM_ROWS * CLK_PERIOD_NS;

    logic        clk;
    logic        rst_n;
    logic        upsp_ac_rready;
    logic [23:0] ac_upsp_rdata;
    logic        ac_upsp_rvalid;
    logic        ac_upsp_wready;
    logic [23:0] upsp_ac_wdata;
    logic        upsp_ac_wvalid;

    logic [15:0] lfsr_src;
    logic [15:0] lfsr_snk;
    int          n_checked;
    logic        held_valid;
    logic        held_ready;
    logic [23:0] held_data;
    logic        long_done;

    bicubic_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .upsp_ac_rready (upsp_ac_rready),
        .ac_upsp_rdata  (ac_upsp_rdata),
        .ac_upsp_rvalid (ac_upsp_rvalid),
        .ac_upsp_wready (ac_upsp_wready),
        .upsp_ac_wdata  (upsp_ac_wdata),
        .upsp_ac_wvalid (upsp_ac_wvalid)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    // table fill and rvalid gaps
    function automatic logic [23:0] source_bits(input int n);
        logic [23:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_src = lfsr_next(lfsr_src);
            v = {v[22:0], lfsr_src[0]};
        end
        return v;
    endfunction

    function automatic logic sink_bit();
        lfsr_snk = lfsr_next(lfsr_snk);
        return lfsr_snk[0];
    endfunction

    task automatic fill_table();
        int   y;
        int   x;
        logic mid;
        for (int k = 0; k < 16; k++) begin
            y   = k / 4;
            x   = k % 4;
            mid = (y == 1 || y == 2) && (x == 1 || x == 2);
            win_tab[0][k] = 24'h5A3C96;
            win_tab[1][k] = mid ? 24'hFFFFFF : 24'h000000;
            win_tab[2][k] = mid ? 24'h000000 : 24'hFFFFFF;
            // R flat, G centre peak, B horizontal ramp
            win_tab[3][k] = {8'h10, mid ? 8'd200 : 8'd0, 8'(x * 64)};
        end
        exp_tab[0] = 24'h5A3C96;
        exp_tab[1] = 24'hFFFFFF;
        exp_tab[2] = 24'h000000;
        exp_tab[3] = 24'h10FD60;
        for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 16; k++) begin
                win_tab[r][k] = source_bits(24);
            end
            exp_tab[r] = model_pixel(r);
        end
    endtask

    task automatic send_pixel(input logic [23:0] pix);
        // roughly one idle cycle in four
        while (source_bits(2) == 24'd0) begin
            ac_upsp_rvalid <= 1'b0;
            @(posedge clk);
        end
        ac_upsp_rdata  <= pix;
        ac_upsp_rvalid <= 1'b1;
        // rready is stable mid cycle, the transfer is on the next edge
        @(negedge clk);
        while (!upsp_ac_rready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic hold_write_port();
        logic saw_low;
        saw_low = 1'b0;
        ac_upsp_wready <= 1'b0;
        repeat (LONG_STALL_CYCLES) begin
            @(posedge clk);
            if (!upsp_ac_rready) begin
                saw_low = 1'b1;
            end
        end
        assert (saw_low)
            else fail_run("upsp_ac_rready never fell during a long write stall");
        long_done = 1'b1;
        ac_upsp_wready <= 1'b1;
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        ac_upsp_rdata  = '0;
        ac_upsp_rvalid = 1'b0;
        ac_upsp_wready = 1'b0;
        lfsr_src       = 16'd28115;
        lfsr_snk       = 16'd28115;
        long_done      = 1'b0;
        fill_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (upsp_ac_wvalid === 1'b0)
            else fail_run($sformatf("Error: upsp_ac_wvalid expected 0 got %0h", upsp_ac_wvalid));
        assert (upsp_ac_rready === 1'b1)
            else fail_run($sformatf("Error: upsp_ac_rready expected 1 got %0h", upsp_ac_rready));
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 16; k++) begin
                send_pixel(win_tab[r][k]);
            end
        end
        ac_upsp_rvalid <= 1'b0;
        wait (n_checked == NUM_ROWS);
        // drain time for any stray extra result
        repeat (10) @(posedge clk);
        assert (upsp_ac_wvalid === 1'b0)
            else fail_run("upsp_ac_wvalid raised after the last window");
        $display("sim passed");
        $finish;
    end

    // write side: always ready, then random stalls, one long stall
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (n_checked == LONG_STALL_AT && !long_done) begin
                hold_write_port();
            end else if (n_checked >= RANDOM_STALL_FROM) begin
                ac_upsp_wready <= sink_bit();
            end else begin
                ac_upsp_wready <= 1'b1;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_checked  <= 0;
            held_valid <= 1'b0;
            held_ready <= 1'b0;
            held_data  <= '0;
        end else begin
            if (held_valid && !held_ready) begin
                assert (upsp_ac_wvalid)
                    else fail_run("upsp_ac_wvalid dropped before its write handshake");
                assert (upsp_ac_wdata === held_data)
                    else fail_run($sformatf("Error: upsp_ac_wdata expected %06h got %06h",
                                            held_data, upsp_ac_wdata));
            end
            if (upsp_ac_wvalid && ac_upsp_wready) begin
                assert (n_checked < NUM_ROWS)
                    else fail_run("more results on the write port than windows sent");
                assert (upsp_ac_wdata === exp_tab[n_checked])
                    else fail_run($sformatf(
                        "Error: upsp_ac_wdata expected %06h got %06h (window %0d)",
                        exp_tab[n_checked], upsp_ac_wdata, n_checked));
                n_checked <= n_checked + 1;
            end
            held_valid <= upsp_ac_wvalid;
            held_ready <= ac_upsp_wready;
            held_data  <= upsp_ac_wdata;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Timeout: only %0d of %0d results arrived", n_checked, NUM_ROWS));
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
+incdir+bench
src/pixel_pkg.sv
src/kernel_pkg.sv
src/window_gather.sv
src/bicubic_kernel.sv
src/pixel_merge.sv
src/bicubic_top.sv
bench/bicubic_tb.sv

// File: src/bicubic_kernel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bicubic kernel, one channel
// rows then column, taps -1 9 9 -1, two stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "upsample_macros.svh"

module bicubic_kernel
    import pixel_pkg::*;
    import kernel_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  plane_t   plane,

    output logic     out_valid,
    input  logic     out_ready,
    output channel_t result
);

    function automatic row_sum_t row_filter(input channel_t a, input channel_t b,
                                            input channel_t c, input channel_t d);
        int acc;
        acc = `TAP_INNER * (int'(b) + int'(c)) - `TAP_OUTER * (int'(a) + int'(d));
        return row_sum_t'(acc);
    endfunction

    function automatic col_sum_t col_filter(input row_sum_t a, input row_sum_t b,
                                            input row_sum_t c, input row_sum_t d);
        int acc;
        acc = `TAP_INNER * (int'(b) + int'(c)) - `TAP_OUTER * (int'(a) + int'(d));
        return col_sum_t'(acc);
    endfunction

    row_sum_t row_sums [`WIN_DIM];
    row_sum_t s1_rows  [`WIN_DIM];
    logic     s1_valid;
    logic     s1_adv;
    col_sum_t col_sum;
    col_sum_t scaled;
    channel_t clamped;
    channel_t s2_result;
    logic     s2_valid;
    logic     s2_adv;

    // a stage moves when empty or when the next one moves
    assign s2_adv   = !s2_valid || out_ready;
    assign s1_adv   = !s1_valid || s2_adv;
    assign in_ready = s1_adv;

    always_comb begin
        for (int r = 0; r < `WIN_DIM; r++) begin
            row_sums[r] = row_filter(plane[r*`WIN_DIM],     plane[r*`WIN_DIM + 1],
                                     plane[r*`WIN_DIM + 2], plane[r*`WIN_DIM + 3]);
        end
    end

    // column pass, round half up, then clamp to channel range
    always_comb begin
        col_sum = col_filter(s1_rows[0], s1_rows[1], s1_rows[2], s1_rows[3]);
        scaled  = (col_sum + col_sum_t'(1 << (`ROUND_SHIFT - 1))) >>> `ROUND_SHIFT;
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > col_sum_t'({`CHANNEL_W{1'b1}})) begin
            clamped = '1;
        end else begin
            clamped = scaled[`CHANNEL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= in_valid;
            end
            if (s2_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && s1_adv) begin
            s1_rows <= row_sums;
        end
        if (s1_valid && s2_adv) begin
            s2_result <= clamped;
        end
    end

    assign out_valid = s2_valid;
    assign result    = s2_result;

endmodule

`default_nettype wire

// File: src/bicubic_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bicubic upsampler top
// one interpolated pixel per 4x4 window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bicubic_top
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    output logic   upsp_ac_rready,
    input  pixel_t ac_upsp_rdata,
    input  logic   ac_upsp_rvalid,

    input  logic   ac_upsp_wready,
    output pixel_t upsp_ac_wdata,
    output logic   upsp_ac_wvalid
);

    logic     win_valid;
    logic     win_ready;
    plane_t   r_plane;
    plane_t   g_plane;
    plane_t   b_plane;

    logic     r_in_ready, g_in_ready, b_in_ready;
    logic     r_out_valid, g_out_valid, b_out_valid;
    channel_t r_result, g_result, b_result;
    logic     chan_ready;

    assign win_ready = r_in_ready & g_in_ready & b_in_ready;

    window_gather u_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_data  (ac_upsp_rdata),
        .pix_valid (ac_upsp_rvalid),
        .pix_ready (upsp_ac_rready),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .r_plane   (r_plane),
        .g_plane   (g_plane),
        .b_plane   (b_plane)
    );

    bicubic_kernel u_r_kernel (
        .clk(clk), .rst_n(rst_n),
        .in_valid(win_valid), .in_ready(r_in_ready), .plane(r_plane),
        .out_valid(r_out_valid), .out_ready(chan_ready), .result(r_result)
    );

    bicubic_kernel u_g_kernel (
        .clk(clk), .rst_n(rst_n),
        .in_valid(win_valid), .in_ready(g_in_ready), .plane(g_plane),
        .out_valid(g_out_valid), .out_ready(chan_ready), .result(g_result)
    );

    bicubic_kernel u_b_kernel (
        .clk(clk), .rst_n(rst_n),
        .in_valid(win_valid), .in_ready(b_in_ready), .plane(b_plane),
        .out_valid(b_out_valid), .out_ready(chan_ready), .result(b_result)
    );

    pixel_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .r_valid    (r_out_valid),
        .g_valid    (g_out_valid),
        .b_valid    (b_out_valid),
        .r_value    (r_result),
        .g_value    (g_result),
        .b_value    (b_result),
        .chan_ready (chan_ready),
        .out_valid  (upsp_ac_wvalid),
        .out_ready  (ac_upsp_wready),
        .out_pixel  (upsp_ac_wdata)
    );

endmodule

`default_nettype wire

// File: src/kernel_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// kernel arithmetic types for the bicubic filter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package kernel_pkg;

    // row range -510..4590
    localparam int ROW_SUM_W = 14;
    // column range -18360..83640
    localparam int COL_SUM_W = 18;

    typedef logic signed [ROW_SUM_W-1:0] row_sum_t;
    typedef logic signed [COL_SUM_W-1:0] col_sum_t;

endpackage

`default_nettype wire

// File: src/pixel_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel merge
// packs three channel results into the write register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pixel_merge
    import pixel_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     r_valid,
    input  logic     g_valid,
    input  logic     b_valid,
    input  channel_t r_value,
    input  channel_t g_value,
    input  channel_t b_value,
    output logic     chan_ready,

    output logic     out_valid,
    input  logic     out_ready,
    output pixel_t   out_pixel
);

    logic   all_valid;
    logic   full;
    pixel_t pixel_q;

    assign all_valid = r_valid && g_valid && b_valid;

    // the three kernels only move together
    assign chan_ready = all_valid && (!full || out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (chan_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (chan_ready) begin
            pixel_q <= '{r: r_value, g: g_value, b: b_value};
        end
    end

    assign out_valid = full;
    assign out_pixel = pixel_q;

endmodule

`default_nettype wire

// File: src/pixel_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel format types for the bicubic upsampler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "upsample_macros.svh"

package pixel_pkg;

    typedef logic [`CHANNEL_W-1:0] channel_t;

    // first member lands in the top byte
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } pixel_t;

    // one colour of a window, index 0 is top-left
    typedef channel_t [`WIN_PIXELS-1:0] plane_t;

endpackage

`default_nettype wire

// File: src/upsample_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bicubic upsampler constants
// pixel format, window geometry, kernel taps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UPSAMPLE_MACROS_SVH
`define UPSAMPLE_MACROS_SVH

`define CHANNEL_W     8
`define NUM_CHANNELS  3
`define WIN_DIM       4
`define WIN_PIXELS    16
`define TAP_INNER     9
`define TAP_OUTER     1
`define ROUND_SHIFT   8

`endif

// File: src/window_gather.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window gather
// collects 16 raster pixels into R, G and B planes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "upsample_macros.svh"

module window_gather
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  pixel_t pix_data,
    input  logic   pix_valid,
    output logic   pix_ready,

    output logic   win_valid,
    input  logic   win_ready,
    output plane_t r_plane,
    output plane_t g_plane,
    output plane_t b_plane
);

    localparam int CNT_W = $clog2(`WIN_PIXELS);

    logic [CNT_W-1:0] cnt;
    logic             full;
    logic             pix_fire;
    logic             last_pix;
    plane_t           r_q;
    plane_t           g_q;
    plane_t           b_q;

    // a full window still lets a pixel in on the edge it leaves
    assign pix_ready = !full || win_ready;
    assign pix_fire  = pix_valid && pix_ready;
    assign last_pix  = (cnt == CNT_W'(`WIN_PIXELS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            full <= 1'b0;
        end else begin
            if (pix_fire) begin
                cnt <= last_pix ? '0 : cnt + 1'b1;
            end
            if (pix_fire && last_pix) begin
                full <= 1'b1;
            end else if (full && win_ready) begin
                full <= 1'b0;
            end
        end
    end

    // split each pixel into its channel slots
    always_ff @(posedge clk) begin
        if (pix_fire) begin
            r_q[cnt] <= pix_data.r;
            g_q[cnt] <= pix_data.g;
            b_q[cnt] <= pix_data.b;
        end
    end

    assign win_valid = full;
    assign r_plane   = r_q;
    assign g_plane   = g_q;
    assign b_plane   = b_q;

endmodule

`default_nettype wire
